// ==== Bender.yml ====
package:
  name: lane_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/lane_ctrl_pkg.sv
      - source/lane_ctrl_addr_stage.sv
      - source/lane_ctrl_data_stage.sv
      - source/lane_ctrl_regbank.sv
      - source/lane_ctrl_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/lane_ctrl_tb.sv

// ==== sim/lane_ctrl_tb.sv ====
// ------------------------------
// Directed testbench for the lane control register space.
// Runs AHB-Lite transfers into lane_ctrl_top and checks read data,
// the two-cycle bus response and the lane control outputs.
// ------------------------------
`include "lane_ctrl_consts.svh"

module lane_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import lane_ctrl_pkg::*;

  localparam int          num_lanes  = `LANE_CTRL_NUM_LANES;
  localparam int          clk_ns     = 8;
  localparam logic [31:0] base_addr  = 32'h0001_0000;
  localparam logic [31:0] lane_mask  = (32'h1 << num_lanes) - 1;
  // Transfers per test, in run order
  localparam int          num_xfers  = 24 + 44 + 12 + 27 + 4 + 7;
  localparam int          timeout_ns = (16 + num_xfers * 10 + 200) * clk_ns;

  logic         clk = 1'b0;
  logic         reset;
  logic [31:0]  haddr;
  logic [1:0]   htrans;
  logic [2:0]   hsize;
  logic         hwrite;
  logic [31:0]  hwdata;
  logic         hsel;
  logic         hready;
  logic [31:0]  hrdata;
  logic         hreadyout;
  logic         hresp;
  lane_status_t status;
  lane_ctrl_t   ctrl;

  string        cur_test;
  int           cur_errors;
  int           tests_passed;
  int           tests_failed;
  logic [31:0]  exp_enable;
  logic [31:0]  exp_ie;
  logic [31:0]  exp_seq [num_lanes];
  logic [31:0]  exp_len [num_lanes];

  always #(clk_ns / 2) clk = ~clk;

  lane_ctrl_top uut (
    .clk       (clk),
    .reset     (reset),
    .haddr     (haddr),
    .htrans    (htrans),
    .hsize     (hsize),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hsel      (hsel),
    .hready    (hready),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .status    (status),
    .ctrl      (ctrl)
  );

  // ------------------------------
  // Reporting
  // ------------------------------
  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("** Error: %s: %s expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
    cur_errors++;
  endtask

  task automatic plain_error(input string msg);
    $display("%s: %s", cur_test, msg);
    cur_errors++;
  endtask

  task automatic begin_test(input string name);
    cur_test   = name;
    cur_errors = 0;
  endtask

  task automatic end_test();
    if (cur_errors == 0) begin
      $display("ok    %s", cur_test);
      tests_passed++;
    end else begin
      $display("fail  %s (%0d errors)", cur_test, cur_errors);
      tests_failed++;
    end
  endtask

  // Data bits that an AHB write of this size and address may change
  function automatic logic [31:0] byte_mask(input logic [2:0] size, input logic [31:0] addr);
    case (size)
      3'd0:    return 32'h0000_00FF << (8 * addr[1:0]);
      3'd1:    return 32'h0000_FFFF << (16 * addr[1]);
      default: return 32'hFFFF_FFFF;
    endcase
  endfunction

  // ------------------------------
  // Bus transfers
  // ------------------------------
  // Ends at the falling edge of the second data-phase cycle
  task automatic bus_transfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                              input logic [31:0] wdata, input logic expect_err,
                              output logic [31:0] rdata);
    logic first_resp;
    int   waits;
    @(posedge clk);
    haddr  <= addr;
    htrans <= 2'b10;
    hsize  <= size;
    hwrite <= wr;
    hsel   <= 1'b1;
    @(posedge clk);
    htrans <= 2'b00;
    hsel   <= 1'b0;
    hwdata <= wdata;
    waits = 0;
    @(negedge clk);
    first_resp = hresp;
    while (!hreadyout && waits < 8) begin
      waits++;
      @(negedge clk);
    end
    rdata = hrdata;
    if (waits != 1) begin
      plain_error($sformatf("transfer at 0x%08h held hreadyout low for %0d cycles instead of 1",
                            addr, waits));
    end
    if (first_resp !== expect_err) value_error("hresp in first cycle", expect_err, first_resp);
    if (hresp !== expect_err) value_error("hresp in second cycle", expect_err, hresp);
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [2:0] size, input logic [31:0] data);
    logic [31:0] unused;
    bus_transfer(1'b1, addr, size, data, 1'b0, unused);
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_transfer(1'b0, addr, 3'd2, 32'h0, 1'b0, rdata);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic reset_values();
    logic [31:0] rdata;
    begin_test("reset_values");
    @(negedge clk);
    if (ctrl !== '0) plain_error("ctrl outputs are not all zero after reset");
    if (hreadyout !== 1'b1) value_error("hreadyout", 1, hreadyout);
    if (hresp !== 1'b0) value_error("hresp", 0, hresp);
    if (hrdata !== 0) value_error("idle hrdata", 0, hrdata);
    // enable, ie, start and clear
    for (int a = 0; a < 16; a += 4) begin
      ahb_read(base_addr + a, rdata);
      if (rdata !== 0) value_error($sformatf("register 0x%02h", a), 0, rdata);
    end
    for (int n = 0; n < num_lanes; n++) begin
      ahb_read(base_addr + `LANE_CTRL_OFS_SEQUENCE + 4 * n, rdata);
      if (rdata !== 0) value_error($sformatf("sequence[%0d]", n), 0, rdata);
      ahb_read(base_addr + `LANE_CTRL_OFS_LENGTH + 4 * n, rdata);
      if (rdata !== 0) value_error($sformatf("length[%0d]", n), 0, rdata);
    end
    end_test();
  endtask

  task automatic word_readback();
    logic [31:0] val;
    logic [31:0] rdata;
    begin_test("word_readback");
    val = $urandom();
    ahb_write(base_addr + `LANE_CTRL_OFS_ENABLE, 3'd2, val);
    exp_enable = val & lane_mask;
    val = $urandom();
    ahb_write(base_addr + `LANE_CTRL_OFS_IE, 3'd2, val);
    exp_ie = val & lane_mask;
    for (int n = 0; n < num_lanes; n++) begin
      exp_seq[n] = $urandom();
      ahb_write(base_addr + `LANE_CTRL_OFS_SEQUENCE + 4 * n, 3'd2, exp_seq[n]);
      exp_len[n] = $urandom();
      ahb_write(base_addr + `LANE_CTRL_OFS_LENGTH + 4 * n, 3'd2, exp_len[n]);
    end
    // Last write lands on the next edge
    @(negedge clk);
    if (32'(ctrl.enable) !== exp_enable) value_error("ctrl.enable", exp_enable, 32'(ctrl.enable));
    if (32'(ctrl.ie) !== exp_ie) value_error("ctrl.ie", exp_ie, 32'(ctrl.ie));
    ahb_read(base_addr + `LANE_CTRL_OFS_ENABLE, rdata);
    if (rdata !== exp_enable) value_error("enable", exp_enable, rdata);
    ahb_read(base_addr + `LANE_CTRL_OFS_IE, rdata);
    if (rdata !== exp_ie) value_error("ie", exp_ie, rdata);
    for (int n = 0; n < num_lanes; n++) begin
      if (ctrl.seq[n] !== exp_seq[n]) value_error("ctrl.seq", exp_seq[n], ctrl.seq[n]);
      if (ctrl.length[n] !== exp_len[n]) value_error("ctrl.length", exp_len[n], ctrl.length[n]);
      ahb_read(base_addr + `LANE_CTRL_OFS_SEQUENCE + 4 * n, rdata);
      if (rdata !== exp_seq[n]) value_error($sformatf("sequence[%0d]", n), exp_seq[n], rdata);
      ahb_read(base_addr + `LANE_CTRL_OFS_LENGTH + 4 * n, rdata);
      if (rdata !== exp_len[n]) value_error($sformatf("length[%0d]", n), exp_len[n], rdata);
    end
    end_test();
  endtask

  task automatic partial_writes();
    logic [31:0] addr;
    logic [31:0] val;
    logic [31:0] mask;
    logic [31:0] rdata;
    logic [2:0]  size;
    begin_test("partial_writes");
    // Four byte writes, then both halfwords of length[3]
    for (int k = 0; k < 6; k++) begin
      size = (k < 4) ? 3'd0 : 3'd1;
      addr = base_addr + `LANE_CTRL_OFS_LENGTH + 12 + ((k < 4) ? k : 2 * (k - 4));
      val  = $urandom();
      ahb_write(addr, size, val);
      mask = byte_mask(size, addr);
      exp_len[3] = (exp_len[3] & ~mask) | (val & mask);
      ahb_read(base_addr + `LANE_CTRL_OFS_LENGTH + 12, rdata);
      if (rdata !== exp_len[3]) value_error($sformatf("length[3] step %0d", k), exp_len[3], rdata);
    end
    end_test();
  endtask

  task automatic status_reads();
    lane_status_t stat;
    logic [31:0]  rdata;
    begin_test("status_reads");
    stat.status     = lane_bits_t'($urandom());
    stat.int_status = lane_bits_t'($urandom());
    for (int n = 0; n < num_lanes; n++) begin
      stat.match_count[n] = $urandom();
    end
    @(posedge clk);
    status <= stat;
    // Second pass follows writes to the read-only registers
    for (int pass = 0; pass < 2; pass++) begin
      ahb_read(base_addr + `LANE_CTRL_OFS_STATUS, rdata);
      if (rdata !== 32'(stat.status)) value_error("status", 32'(stat.status), rdata);
      ahb_read(base_addr + `LANE_CTRL_OFS_INT_STATUS, rdata);
      if (rdata !== 32'(stat.int_status)) value_error("int_status", 32'(stat.int_status), rdata);
      for (int n = 0; n < num_lanes; n++) begin
        ahb_read(base_addr + `LANE_CTRL_OFS_MATCH + 4 * n, rdata);
        if (rdata !== stat.match_count[n]) begin
          value_error($sformatf("match[%0d]", n), stat.match_count[n], rdata);
        end
      end
      if (pass == 0) begin
        ahb_write(base_addr + `LANE_CTRL_OFS_STATUS, 3'd2, ~32'(stat.status));
        ahb_write(base_addr + `LANE_CTRL_OFS_INT_STATUS, 3'd2, ~32'(stat.int_status));
        ahb_write(base_addr + `LANE_CTRL_OFS_MATCH + 16, 3'd2, ~stat.match_count[4]);
      end
    end
    end_test();
  endtask

  task automatic pulse_behavior();
    logic [31:0] ofs;
    logic [31:0] val;
    logic [31:0] seen;
    logic [31:0] rdata;
    begin_test("pulse_behavior");
    for (int r = 0; r < 2; r++) begin
      ofs = (r == 0) ? `LANE_CTRL_OFS_START : `LANE_CTRL_OFS_CLEAR;
      val = $urandom() | 32'h1;
      ahb_write(base_addr + ofs, 3'd2, val);
      seen = (r == 0) ? 32'(ctrl.start) : 32'(ctrl.clear);
      if (seen !== 0) value_error("pulse before write edge", 0, seen);
      @(negedge clk);
      seen = (r == 0) ? 32'(ctrl.start) : 32'(ctrl.clear);
      if (seen !== (val & lane_mask)) value_error("pulse cycle", val & lane_mask, seen);
      @(negedge clk);
      seen = (r == 0) ? 32'(ctrl.start) : 32'(ctrl.clear);
      if (seen !== 0) value_error("cycle after pulse", 0, seen);
      ahb_read(base_addr + ofs, rdata);
      if (rdata !== 0) value_error("command register read", 0, rdata);
    end
    end_test();
  endtask

  task automatic error_responses();
    logic [31:0] rdata;
    begin_test("error_responses");
    bus_transfer(1'b1, base_addr + 32'h018, 3'd2, $urandom(), 1'b1, rdata);
    bus_transfer(1'b0, base_addr + 32'h068, 3'd2, 32'h0, 1'b1, rdata);
    bus_transfer(1'b1, base_addr + 32'h100, 3'd2, $urandom(), 1'b1, rdata);
    // Doubleword size, then a halfword at an odd address
    bus_transfer(1'b1, base_addr + `LANE_CTRL_OFS_ENABLE, 3'd3, ~exp_enable, 1'b1, rdata);
    bus_transfer(1'b1, base_addr + `LANE_CTRL_OFS_LENGTH + 1, 3'd1, ~exp_len[0], 1'b1, rdata);
    ahb_read(base_addr + `LANE_CTRL_OFS_ENABLE, rdata);
    if (rdata !== exp_enable) value_error("enable after errors", exp_enable, rdata);
    ahb_read(base_addr + `LANE_CTRL_OFS_LENGTH, rdata);
    if (rdata !== exp_len[0]) value_error("length[0] after errors", exp_len[0], rdata);
    end_test();
  endtask

  // ------------------------------
  // Run
  // ------------------------------
  initial begin
    void'($urandom(33));
    reset        = 1'b1;
    haddr        = '0;
    htrans       = 2'b00;
    hsize        = 3'd0;
    hwrite       = 1'b0;
    hwdata       = '0;
    hsel         = 1'b0;
    hready       = 1'b1;
    status       = '0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    reset_values();
    word_readback();
    partial_writes();
    status_reads();
    pulse_behavior();
    error_responses();
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", timeout_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== source/lane_ctrl_addr_stage.sv ====
// ------------------------------
// AHB-Lite address phase decode. Qualifies the transfer, maps the
// offset to a register id and lane, builds the byte strobes and
// error flag, and registers them for the first data-phase cycle.
// ------------------------------
`include "lane_ctrl_consts.svh"

module lane_ctrl_addr_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [31:0]                   haddr,
  input  logic [1:0]                    htrans,
  input  logic [2:0]                    hsize,
  input  logic                          hwrite,
  input  logic                          hsel,
  input  logic                          hready,
  output lane_ctrl_pkg::lane_ctrl_req_t req
);
  import lane_ctrl_pkg::*;

  logic                              accept;
  logic [`LANE_CTRL_ADDR_WIDTH-1:0]  word_ofs;
  logic [`LANE_CTRL_ADDR_WIDTH-1:0]  array_base;
  reg_id_t                           dec_id;
  lane_idx_t                         dec_lane;
  logic                              dec_hit;
  logic                              size_err;
  logic                              align_err;
  strb_t                             dec_strb;

  // NONSEQ or SEQ only
  assign accept     = hsel & htrans[1] & hready;
  assign word_ofs   = {haddr[`LANE_CTRL_ADDR_WIDTH-1:2], 2'b00};
  assign array_base = {word_ofs[`LANE_CTRL_ADDR_WIDTH-1:6], 6'b00_0000};

  // ------------------------------
  // Offset decode
  // ------------------------------
  always_comb begin
    dec_id   = reg_enable;
    dec_lane = '0;
    dec_hit  = 1'b1;
    case (word_ofs)
      `LANE_CTRL_OFS_ENABLE:     dec_id = reg_enable;
      `LANE_CTRL_OFS_IE:         dec_id = reg_ie;
      `LANE_CTRL_OFS_START:      dec_id = reg_start;
      `LANE_CTRL_OFS_CLEAR:      dec_id = reg_clear;
      `LANE_CTRL_OFS_STATUS:     dec_id = reg_status;
      `LANE_CTRL_OFS_INT_STATUS: dec_id = reg_int_status;
      default: begin
        dec_lane = word_ofs[5:2];
        dec_hit  = (word_ofs[5:2] < `LANE_CTRL_NUM_LANES);
        case (array_base)
          `LANE_CTRL_OFS_SEQUENCE: dec_id = reg_sequence;
          `LANE_CTRL_OFS_LENGTH:   dec_id = reg_length;
          `LANE_CTRL_OFS_MATCH:    dec_id = reg_match;
          default:                 dec_hit = 1'b0;
        endcase
      end
    endcase
  end

  // Byte lanes from size and low address bits
  always_comb begin
    case (hsize)
      3'd0:    dec_strb = strb_t'(1) << haddr[1:0];
      3'd1:    dec_strb = haddr[1] ? 4'b1100 : 4'b0011;
      default: dec_strb = 4'b1111;
    endcase
  end

  assign size_err  = (hsize > 3'd2);
  assign align_err = ((hsize == 3'd1) & haddr[0]) |
                     ((hsize == 3'd2) & (haddr[1:0] != 2'b00));

  always_ff @(posedge clk) begin
    req.valid  <= accept;
    req.write  <= hwrite;
    req.reg_id <= dec_id;
    req.lane   <= dec_lane;
    req.strb   <= dec_strb;
    req.error  <= ~dec_hit | size_err | align_err;
    if (reset) begin
      req.valid <= 1'b0;
    end
  end

endmodule

// ==== source/lane_ctrl_consts.svh ====
// ------------------------------
// Lane count, bus widths and register offsets of the lane control
// register space. Include in every file that sizes or decodes it.
// ------------------------------
`ifndef LANE_CTRL_CONSTS_SVH
`define LANE_CTRL_CONSTS_SVH

`define LANE_CTRL_NUM_LANES       10
`define LANE_CTRL_DATA_WIDTH      32
`define LANE_CTRL_ADDR_WIDTH      12

// Lane-bit registers, one bit per lane
`define LANE_CTRL_OFS_ENABLE      12'h000
`define LANE_CTRL_OFS_IE          12'h004
`define LANE_CTRL_OFS_START       12'h008
`define LANE_CTRL_OFS_CLEAR       12'h00C
`define LANE_CTRL_OFS_STATUS      12'h010
`define LANE_CTRL_OFS_INT_STATUS  12'h014

// Per-lane word arrays, lane n at base + 4n
`define LANE_CTRL_OFS_SEQUENCE    12'h040
`define LANE_CTRL_OFS_LENGTH      12'h080
`define LANE_CTRL_OFS_MATCH       12'h0C0

`endif

// ==== source/lane_ctrl_data_stage.sv ====
// ------------------------------
// AHB-Lite data phase. Joins the write data to the decoded request,
// holds it as the access for the second data-phase cycle, and runs
// the two-cycle HREADYOUT/HRESP response.
// ------------------------------
`include "lane_ctrl_consts.svh"

module lane_ctrl_data_stage (
  input  logic                             clk,
  input  logic                             reset,
  input  lane_ctrl_pkg::lane_ctrl_req_t    req,
  input  logic [`LANE_CTRL_DATA_WIDTH-1:0] hwdata,
  output lane_ctrl_pkg::lane_ctrl_access_t access,
  output logic                             hreadyout,
  output logic                             hresp
);
  import lane_ctrl_pkg::*;

  logic first_err;
  logic second_err;

  // ------------------------------
  // Access register
  // ------------------------------
  always_ff @(posedge clk) begin
    access.req   <= req;
    access.wdata <= word_t'(hwdata);
    if (reset) begin
      access.req.valid <= 1'b0;
    end
  end

  // Wait state on every first data-phase cycle
  assign hreadyout = ~req.valid;

  // Only one of the two cycles can be live at a time
  assign first_err  = req.valid & req.error;
  assign second_err = access.req.valid & access.req.error;
  assign hresp      = first_err | second_err;

endmodule

// ==== source/lane_ctrl_pkg.sv ====
// ------------------------------
// Types shared by the lane control pipeline: register ids, the
// request and access records between stages, and the lane ports.
// ------------------------------
`include "lane_ctrl_consts.svh"

package lane_ctrl_pkg;

  typedef logic [`LANE_CTRL_DATA_WIDTH-1:0]          word_t;
  typedef logic [`LANE_CTRL_DATA_WIDTH/8-1:0]        strb_t;
  typedef logic [`LANE_CTRL_NUM_LANES-1:0]           lane_bits_t;
  typedef logic [$clog2(`LANE_CTRL_NUM_LANES)-1:0]   lane_idx_t;

  typedef enum logic [3:0] {
    reg_enable,
    reg_ie,
    reg_start,
    reg_clear,
    reg_status,
    reg_int_status,
    reg_sequence,
    reg_length,
    reg_match
  } reg_id_t;

  // Registered address phase
  typedef struct packed {
    logic       valid;
    logic       write;
    reg_id_t    reg_id;
    lane_idx_t  lane;
    strb_t      strb;
    logic       error;
  } lane_ctrl_req_t;

  typedef struct packed {
    lane_ctrl_req_t req;
    word_t          wdata;
  } lane_ctrl_access_t;

  typedef struct packed {
    lane_bits_t                          enable;
    lane_bits_t                          ie;
    lane_bits_t                          start;
    lane_bits_t                          clear;
    word_t [`LANE_CTRL_NUM_LANES-1:0]    seq;
    word_t [`LANE_CTRL_NUM_LANES-1:0]    length;
  } lane_ctrl_t;

  typedef struct packed {
    lane_bits_t                          status;
    lane_bits_t                          int_status;
    word_t [`LANE_CTRL_NUM_LANES-1:0]    match_count;
  } lane_status_t;

endpackage

// ==== source/lane_ctrl_regbank.sv ====
// ------------------------------
// Lane control registers. Applies strobed writes from the access,
// turns start and clear writes into one-cycle pulses and returns
// read data from the controls or the lane status inputs.
// ------------------------------
`include "lane_ctrl_consts.svh"

module lane_ctrl_regbank (
  input  logic                             clk,
  input  logic                             reset,
  input  lane_ctrl_pkg::lane_ctrl_access_t access,
  input  lane_ctrl_pkg::lane_status_t      status,
  output lane_ctrl_pkg::lane_ctrl_t        ctrl,
  output logic [`LANE_CTRL_DATA_WIDTH-1:0] hrdata
);
  import lane_ctrl_pkg::*;

  logic      wr_en;
  logic      rd_en;
  word_t     wdata;
  strb_t     strb;
  lane_idx_t lane;
  word_t     pulse_val;
  word_t     rd_val;

  // Merge new bytes into the old word under the strobes
  function automatic word_t apply_strobe(word_t old_val, word_t new_val, strb_t sel);
    word_t result;
    result = old_val;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (sel[b]) begin
        result[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign wr_en = access.req.valid & access.req.write & ~access.req.error;
  assign rd_en = access.req.valid & ~access.req.write & ~access.req.error;
  assign wdata = access.wdata;
  assign strb  = access.req.strb;
  assign lane  = access.req.lane;

  assign pulse_val = apply_strobe('0, wdata, strb);

  // ------------------------------
  // Write side
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl <= '0;
    end else begin
      // Command bits last one cycle
      ctrl.start <= '0;
      ctrl.clear <= '0;
      if (wr_en) begin
        case (access.req.reg_id)
          reg_enable: begin
            ctrl.enable <= lane_bits_t'(apply_strobe(word_t'(ctrl.enable), wdata, strb));
          end
          reg_ie: begin
            ctrl.ie <= lane_bits_t'(apply_strobe(word_t'(ctrl.ie), wdata, strb));
          end
          reg_start: begin
            ctrl.start <= lane_bits_t'(pulse_val);
          end
          reg_clear: begin
            ctrl.clear <= lane_bits_t'(pulse_val);
          end
          reg_sequence: begin
            ctrl.seq[lane] <= apply_strobe(ctrl.seq[lane], wdata, strb);
          end
          reg_length: begin
            ctrl.length[lane] <= apply_strobe(ctrl.length[lane], wdata, strb);
          end
          // Status and match counts ignore writes
          default: begin
          end
        endcase
      end
    end
  end

  // ------------------------------
  // Read side
  // ------------------------------
  always_comb begin
    case (access.req.reg_id)
      reg_enable:     rd_val = word_t'(ctrl.enable);
      reg_ie:         rd_val = word_t'(ctrl.ie);
      reg_status:     rd_val = word_t'(status.status);
      reg_int_status: rd_val = word_t'(status.int_status);
      reg_sequence:   rd_val = ctrl.seq[lane];
      reg_length:     rd_val = ctrl.length[lane];
      reg_match:      rd_val = status.match_count[lane];
      // start and clear read as zero
      default:        rd_val = '0;
    endcase
  end

  assign hrdata = rd_en ? rd_val : '0;

endmodule

// ==== source/lane_ctrl_top.sv ====
// ------------------------------
// Lane control register space on an AHB-Lite slave port.
// Address stage, data stage and register bank in a row; lane
// controls leave on ctrl, training status enters on status.
// ------------------------------
`include "lane_ctrl_consts.svh"

module lane_ctrl_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [31:0]                      haddr,
  input  logic [1:0]                       htrans,
  input  logic [2:0]                       hsize,
  input  logic                             hwrite,
  input  logic [`LANE_CTRL_DATA_WIDTH-1:0] hwdata,
  input  logic                             hsel,
  input  logic                             hready,
  output logic [`LANE_CTRL_DATA_WIDTH-1:0] hrdata,
  output logic                             hreadyout,
  output logic                             hresp,
  input  lane_ctrl_pkg::lane_status_t      status,
  output lane_ctrl_pkg::lane_ctrl_t        ctrl
);
  import lane_ctrl_pkg::*;

  lane_ctrl_req_t    req;
  lane_ctrl_access_t access;

  lane_ctrl_addr_stage u_addr_stage (
    .clk    (clk),
    .reset  (reset),
    .haddr  (haddr),
    .htrans (htrans),
    .hsize  (hsize),
    .hwrite (hwrite),
    .hsel   (hsel),
    .hready (hready),
    .req    (req)
  );

  lane_ctrl_data_stage u_data_stage (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .hwdata    (hwdata),
    .access    (access),
    .hreadyout (hreadyout),
    .hresp     (hresp)
  );

  lane_ctrl_regbank u_regbank (
    .clk    (clk),
    .reset  (reset),
    .access (access),
    .status (status),
    .ctrl   (ctrl),
    .hrdata (hrdata)
  );

endmodule

// ==== tb.f ====
+incdir+source
source/lane_ctrl_pkg.sv
source/lane_ctrl_addr_stage.sv
source/lane_ctrl_data_stage.sv
source/lane_ctrl_regbank.sv
source/lane_ctrl_top.sv
sim/lane_ctrl_tb.sv
